//--- verilog/isa_pkg.sv
package isa_pkg;

	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] sa;
		logic [5:0] funct;
	} r_fields_t;

	typedef struct packed {
		logic [5:0]  opcode;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm;
	} i_fields_t;

	// One word, seen as R-type or I-type.
	typedef union packed {
		r_fields_t r;
		i_fields_t i;
	} instr_t;

	localparam logic [5:0] op_special = 6'b000000; // Selects funct decode.
	localparam logic [5:0] op_andi    = 6'b001100;
	localparam logic [5:0] op_ori     = 6'b001101;
	localparam logic [5:0] op_xori    = 6'b001110;
	localparam logic [5:0] op_lui     = 6'b001111;

	localparam logic [5:0] fn_and  = 6'b100100;
	localparam logic [5:0] fn_or   = 6'b100101;
	localparam logic [5:0] fn_xor  = 6'b100110;
	localparam logic [5:0] fn_nor  = 6'b100111;
	localparam logic [5:0] fn_sll  = 6'b000000;
	localparam logic [5:0] fn_srl  = 6'b000010;
	localparam logic [5:0] fn_sra  = 6'b000011;
	localparam logic [5:0] fn_sllv = 6'b000100;
	localparam logic [5:0] fn_srlv = 6'b000110;
	localparam logic [5:0] fn_srav = 6'b000111;

endpackage

//--- verilog/exec_pkg.sv
package exec_pkg;

	typedef logic [4:0]  reg_addr_t;
	typedef logic [31:0] word_t;

	// ALU class, picks which unit feeds write-back.
	typedef enum logic [2:0] {
		sel_none  = 3'b000,
		sel_logic = 3'b001,
		sel_shift = 3'b010
	} alusel_t;

	// Immediate and variable forms share these codes.
	typedef enum logic [7:0] {
		aop_and = 8'b00100100,
		aop_or  = 8'b00100101,
		aop_xor = 8'b00100110,
		aop_nor = 8'b00100111,
		aop_lui = 8'b00001111,
		aop_sll = 8'b00000000,
		aop_srl = 8'b00000010,
		aop_sra = 8'b00000011
	} aluop_t;

endpackage

//--- verilog/id_ex_if.sv
`timescale 1ns/1ps

interface id_ex_if import exec_pkg::*; ();

	alusel_t   alusel;
	aluop_t    aluop;
	word_t     reg1_data;
	word_t     reg2_data;
	logic      we;
	reg_addr_t waddr;

	modport dec (
		output alusel,
		output aluop,
		output reg1_data,
		output reg2_data,
		output we,
		output waddr
	);

	modport exe (
		input alusel,
		input aluop,
		input reg1_data,
		input reg2_data,
		input we,
		input waddr
	);

endinterface

//--- verilog/regfile.sv
`timescale 1ns/1ps

module regfile import exec_pkg::*; (
	input  logic      clk,
	input  logic      reset_n,
	input  reg_addr_t raddr1,
	input  reg_addr_t raddr2,
	output word_t     rdata1,
	output word_t     rdata2,
	input  logic      wb_we,
	input  reg_addr_t wb_waddr,
	input  word_t     wb_wdata
);

	word_t regs [1:31]; // No storage for r0.

	logic hit1;
	logic hit2;

	assign hit1 = wb_we && wb_waddr == raddr1; // Write-through bypass.
	assign hit2 = wb_we && wb_waddr == raddr2;

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			for (int k = 1; k < 32; k++) begin
				regs[k] <= '0;
			end
		end else if (wb_we && wb_waddr != '0) begin
			regs[wb_waddr] <= wb_wdata;
		end
	end

	assign rdata1 = (raddr1 == '0) ? '0 : (hit1 ? wb_wdata : regs[raddr1]);
	assign rdata2 = (raddr2 == '0) ? '0 : (hit2 ? wb_wdata : regs[raddr2]);

endmodule

//--- verilog/id.sv
`timescale 1ns/1ps

module id import isa_pkg::*, exec_pkg::*; (
	input  instr_t    instr,
	output reg_addr_t raddr1,
	output reg_addr_t raddr2,
	input  word_t     rdata1,
	input  word_t     rdata2,
	id_ex_if.dec      to_ex
);

	logic sa_as_reg1;  // Shift amount field replaces rs.
	logic imm_as_reg2; // Zero-extended imm replaces rt.

	assign raddr1 = instr.r.rs;
	assign raddr2 = instr.r.rt;

	always_comb begin
		to_ex.alusel = sel_none;
		to_ex.aluop = aop_and;
		to_ex.we = 1'b0;
		sa_as_reg1 = 1'b0;
		imm_as_reg2 = 1'b0;
		case (instr.r.opcode)
			op_special: begin
				case (instr.r.funct)
					fn_and: begin
						to_ex.alusel = sel_logic;
						to_ex.aluop = aop_and;
						to_ex.we = 1'b1;
					end
					fn_or: begin
						to_ex.alusel = sel_logic;
						to_ex.aluop = aop_or;
						to_ex.we = 1'b1;
					end
					fn_xor: begin
						to_ex.alusel = sel_logic;
						to_ex.aluop = aop_xor;
						to_ex.we = 1'b1;
					end
					fn_nor: begin
						to_ex.alusel = sel_logic;
						to_ex.aluop = aop_nor;
						to_ex.we = 1'b1;
					end
					fn_sll, fn_sllv: begin
						to_ex.alusel = sel_shift;
						to_ex.aluop = aop_sll;
						to_ex.we = 1'b1;
						sa_as_reg1 = (instr.r.funct == fn_sll);
					end
					fn_srl, fn_srlv: begin
						to_ex.alusel = sel_shift;
						to_ex.aluop = aop_srl;
						to_ex.we = 1'b1;
						sa_as_reg1 = (instr.r.funct == fn_srl);
					end
					fn_sra, fn_srav: begin
						to_ex.alusel = sel_shift;
						to_ex.aluop = aop_sra;
						to_ex.we = 1'b1;
						sa_as_reg1 = (instr.r.funct == fn_sra);
					end
					default: ;
				endcase
			end
			op_andi: begin
				to_ex.alusel = sel_logic;
				to_ex.aluop = aop_and;
				to_ex.we = 1'b1;
				imm_as_reg2 = 1'b1;
			end
			op_ori: begin
				to_ex.alusel = sel_logic;
				to_ex.aluop = aop_or;
				to_ex.we = 1'b1;
				imm_as_reg2 = 1'b1;
			end
			op_xori: begin
				to_ex.alusel = sel_logic;
				to_ex.aluop = aop_xor;
				to_ex.we = 1'b1;
				imm_as_reg2 = 1'b1;
			end
			op_lui: begin
				to_ex.alusel = sel_logic;
				to_ex.aluop = aop_lui;
				to_ex.we = 1'b1;
				imm_as_reg2 = 1'b1; // Execute shifts it up.
			end
			default: ;
		endcase
	end

	assign to_ex.reg1_data = sa_as_reg1 ? {27'd0, instr.r.sa} : rdata1;
	assign to_ex.reg2_data = imm_as_reg2 ? {16'd0, instr.i.imm} : rdata2;

	// rd for R-type, rt otherwise.
	assign to_ex.waddr = (instr.r.opcode == op_special) ? instr.r.rd : instr.i.rt;

endmodule

//--- verilog/ex.sv
`timescale 1ns/1ps

module ex import exec_pkg::*; (
	input  logic      clk,
	input  logic      reset_n,
	id_ex_if.exe      from_id,
	output logic      wb_we,
	output reg_addr_t wb_waddr,
	output word_t     wb_wdata
);

	word_t      logic_out;
	word_t      shift_out;
	logic [4:0] shamt;

	assign shamt = from_id.reg1_data[4:0]; // Upper bits ignored.

	always_comb begin
		case (from_id.aluop)
			aop_and: begin
				logic_out = from_id.reg1_data & from_id.reg2_data;
			end
			aop_or: begin
				logic_out = from_id.reg1_data | from_id.reg2_data;
			end
			aop_xor: begin
				logic_out = from_id.reg1_data ^ from_id.reg2_data;
			end
			aop_nor: begin
				logic_out = ~(from_id.reg1_data | from_id.reg2_data);
			end
			aop_lui: begin
				logic_out = {from_id.reg2_data[15:0], 16'd0};
			end
			default: begin
				logic_out = '0;
			end
		endcase
	end

	always_comb begin
		case (from_id.aluop)
			aop_sll: begin
				shift_out = from_id.reg2_data << shamt;
			end
			aop_srl: begin
				shift_out = from_id.reg2_data >> shamt;
			end
			aop_sra: begin
				shift_out = $signed(from_id.reg2_data) >>> shamt; // Sign fill.
			end
			default: begin
				shift_out = '0;
			end
		endcase
	end

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			wb_we <= 1'b0;
			wb_waddr <= '0;
			wb_wdata <= '0;
		end else begin
			wb_we <= from_id.we;
			wb_waddr <= from_id.waddr;
			case (from_id.alusel)
				sel_logic: begin
					wb_wdata <= logic_out;
				end
				sel_shift: begin
					wb_wdata <= shift_out;
				end
				default: begin
					wb_wdata <= '0; // No-op words.
				end
			endcase
		end
	end

endmodule

//--- verilog/core_top.sv
`timescale 1ns/1ps

module core_top import isa_pkg::*, exec_pkg::*; (
	input  logic        clk,
	input  logic        reset_n,
	input  logic [31:0] instr,
	output logic        wb_we,
	output reg_addr_t   wb_waddr,
	output word_t       wb_wdata
);

	reg_addr_t raddr1;
	reg_addr_t raddr2;
	word_t     rdata1;
	word_t     rdata2;

	id_ex_if id_ex ();

	id id_i (
		.instr  (instr_t'(instr)),
		.raddr1 (raddr1),
		.raddr2 (raddr2),
		.rdata1 (rdata1),
		.rdata2 (rdata2),
		.to_ex  (id_ex.dec)
	);

	regfile regfile_i (
		.clk      (clk),
		.reset_n  (reset_n),
		.raddr1   (raddr1),
		.raddr2   (raddr2),
		.rdata1   (rdata1),
		.rdata2   (rdata2),
		.wb_we    (wb_we),    // Write-back from ex.
		.wb_waddr (wb_waddr),
		.wb_wdata (wb_wdata)
	);

	ex ex_i (
		.clk      (clk),
		.reset_n  (reset_n),
		.from_id  (id_ex.exe),
		.wb_we    (wb_we),
		.wb_waddr (wb_waddr),
		.wb_wdata (wb_wdata)
	);

endmodule

//--- test/core_tb.sv
`timescale 1ns/1ps

module core_tb;

	localparam int          clk_period   = 100;
	localparam int          reset_cycles = 3;
	localparam              trace_path   = "test/core_trace.txt";
	localparam logic [31:0] idle_word    = 32'hfc000000; // Opcode 0x3f, rt 0.

	logic        clk;
	logic        reset_n;
	logic [31:0] instr;
	logic        wb_we;
	logic [4:0]  wb_waddr;
	logic [31:0] wb_wdata;

	// Trace columns, one entry per step.
	logic [31:0] step_instr [$];
	logic        step_we [$];
	logic [4:0]  step_waddr [$];
	logic [31:0] step_wdata [$];
	int          step_test [$];
	int          step_line [$];

	int    num_steps;
	bit    trace_ready;
	int    check_count;
	int    error_count;
	int    test_count;
	string context_str;

	core_top core_top_i (
		.clk      (clk),
		.reset_n  (reset_n),
		.instr    (instr),
		.wb_we    (wb_we),
		.wb_waddr (wb_waddr),
		.wb_wdata (wb_wdata)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#(clk_period / 2) clk = ~clk;
		end
	end

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("ERR %s got %08h expected %08h (%s)", name, got, exp, context_str);
		end
	endtask

	task automatic expect_idle();
		check("wb_we", wb_we, 32'd0);
		check("wb_waddr", wb_waddr, 32'd0);
		check("wb_wdata", wb_wdata, 32'd0);
	endtask

	task automatic report_test(input string label, input int start_errors);
		int errs;
		errs = error_count - start_errors;
		test_count++;
		if (errs == 0) begin
			$display("%s: pass", label);
		end else begin
			$display("%s: %0d errors", label, errs);
		end
	endtask

	// Lines that do not start with five fields are comments.
	task automatic load_trace(output bit ok);
		int               fd;
		int               code;
		int               line_no;
		int               fields;
		logic [8*256-1:0] text;
		logic [31:0]      f_instr;
		logic [31:0]      f_we;
		logic [31:0]      f_waddr;
		logic [31:0]      f_wdata;
		int               f_test;
		ok = 1'b0;
		line_no = 0;
		fd = $fopen(trace_path, "r");
		if (fd == 0) begin
			$display("Cannot open the trace file %s.", trace_path);
		end else begin
			while (!$feof(fd)) begin
				text = '0;
				code = $fgets(text, fd);
				if (code != 0) begin
					line_no++;
					fields = $sscanf(text, "%h %h %h %h %d",
						f_instr, f_we, f_waddr, f_wdata, f_test);
					if (fields == 5) begin
						step_instr.push_back(f_instr);
						step_we.push_back(f_we[0]);
						step_waddr.push_back(f_waddr[4:0]);
						step_wdata.push_back(f_wdata);
						step_test.push_back(f_test);
						step_line.push_back(line_no);
					end
				end
			end
			$fclose(fd);
			num_steps = step_instr.size();
			if (num_steps == 0) begin
				$display("The trace file %s holds no steps.", trace_path);
			end else begin
				ok = 1'b1;
			end
		end
	endtask

	task automatic run_reset();
		int start_errors;
		start_errors = error_count;
		for (int k = 0; k < reset_cycles; k++) begin
			@(negedge clk);
			context_str = $sformatf("reset cycle %0d", k + 1);
			expect_idle();
		end
		reset_n = 1'b1;
		@(negedge clk); // Idle word has passed through execute.
		context_str = "first cycle after reset";
		expect_idle();
		report_test("reset", start_errors);
	endtask

	// Each word is driven on a falling edge and its result checked on the next.
	task automatic run_trace();
		int start_errors;
		start_errors = error_count;
		for (int i = 0; i < num_steps; i++) begin
			instr = step_instr[i];
			@(negedge clk);
			context_str = $sformatf("trace line %0d", step_line[i]);
			check("wb_we", wb_we, step_we[i]);
			if (step_we[i]) begin
				check("wb_waddr", wb_waddr, step_waddr[i]); // Only meaningful for a write.
			end
			check("wb_wdata", wb_wdata, step_wdata[i]);
			if (i == num_steps - 1 || step_test[i + 1] != step_test[i]) begin
				report_test($sformatf("test %0d", step_test[i]), start_errors);
				start_errors = error_count;
			end
		end
	endtask

	initial begin
		wait (trace_ready);
		#((num_steps + reset_cycles + 10) * clk_period);
		$display("Timeout: the trace did not finish in the expected time.");
		$display("TESTS FAILED");
		$finish;
	end

	initial begin
		bit ok;
		instr = idle_word;
		reset_n = 1'b0;
		trace_ready = 1'b0;
		check_count = 0;
		error_count = 0;
		test_count = 0;
		context_str = "";
		load_trace(ok);
		if (!ok) begin
			$display("TESTS FAILED");
			$finish;
		end else begin
			trace_ready = 1'b1;
			run_reset();
			run_trace();
			$display("%0d tests, %0d checks, %0d errors", test_count, check_count,
				error_count);
			if (error_count == 0) begin
				$display("TESTS PASSED");
			end else begin
				$display("TESTS FAILED");
			end
			$finish;
		end
	end

endmodule

//--- test/core_trace.txt
# Columns: instr (hex), wb_we, wb_waddr (hex), wb_wdata (hex), test number (decimal).
# wb_waddr is not compared when wb_we is 0. Text after the fifth field is a note.
# Test 1: first words read registers that are still zero.
00430825 1 01 00000000 1   # or   r1, r2, r3
00a62027 1 04 ffffffff 1   # nor  r4, r5, r6
# Test 2: immediates and lui.
34011234 1 01 00001234 2   # ori  r1, r0, 0x1234
382200ff 1 02 000012cb 2   # xori r2, r1, 0x00ff
3c03f0f0 1 03 f0f00000 2   # lui  r3, 0xf0f0
34638001 1 03 f0f08001 2   # ori  r3, r3, 0x8001
38858001 1 05 ffff7ffe 2   # xori r5, r4, 0x8001
3086a5a5 1 06 0000a5a5 2   # andi r6, r4, 0xa5a5
# Test 3: R-type logic, each word using the result just before it.
00653824 1 07 f0f00000 3   # and  r7, r3, r5
00e64025 1 08 f0f0a5a5 3   # or   r8, r7, r6
01014826 1 09 f0f0b791 3   # xor  r9, r8, r1
01225027 1 0a 0f0f4824 3   # nor  r10, r9, r2
014a5824 1 0b 0f0f4824 3   # and  r11, r10, r10
# Test 4: shifts by sa and by register.
00016100 1 0c 00012340 4   # sll  r12, r1, 4
00036a02 1 0d 00f0f080 4   # srl  r13, r3, 8
00037203 1 0e fff0f080 4   # sra  r14, r3, 8
340fffe4 1 0f 0000ffe4 4   # ori  r15, r0, 0xffe4
01e68004 1 10 000a5a50 4   # sllv r16, r6, r15
01e38806 1 11 0f0f0800 4   # srlv r17, r3, r15
01e39007 1 12 ff0f0800 4   # srav r18, r3, r15
01f29807 1 13 fff0f080 4   # srav r19, r18, r15
0008a7c3 1 14 ffffffff 4   # sra  r20, r8, 31
0008afc2 1 15 00000001 4   # srl  r21, r8, 31
# Test 5: register 0 and unsupported words.
34800001 1 00 ffffffff 5   # ori  r0, r4, 0x0001
0000b025 1 16 00000000 5   # or   r22, r0, r0
38175a5a 1 17 00005a5a 5   # xori r23, r0, 0x5a5a
8c230004 0 00 00000000 5   # lw   r3, 4(r1)
0022c020 0 00 00000000 5   # add  r24, r1, r2
0063c824 1 19 f0f08001 5   # and  r25, r3, r3
00000000 1 00 00000000 5   # sll  r0, r0, 0

//--- project.f
verilog/isa_pkg.sv
verilog/exec_pkg.sv
verilog/id_ex_if.sv
verilog/regfile.sv
verilog/id.sv
verilog/ex.sv
verilog/core_top.sv
test/core_tb.sv
